//--- dv/clock_gen.sv
`default_nettype none

module clock_gen
(
	output logic CLOCK_50,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ns;

	// 100 ns period
	initial
	begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50;
	end

	// Reset held for 16 cycles, released on a rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (16) @(posedge CLOCK_50);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/rms_tb.sv
`default_nettype none

module rms_tb
	import rms_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	logic CLOCK_50;
	logic rst_n;
	logic src_empty;
	logic [WORD_W-1:0] src_readdata;
	logic snk_full;
	logic src_read;
	logic snk_write;
	logic [WORD_W-1:0] snk_writedata;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;

	// Source FIFO contents and a record of every sample sent
	logic [WORD_W-1:0] src_queue [$];
	logic [SAMPLE_W-1:0] sent_samples [0:63];
	int samples_sent;
	int results_seen;
	logic [WORD_W-1:0] last_word;
	// Sink back-pressure
	logic [31:0] lfsr_state;
	logic backpressure_en;
	logic full_level;
	int stretch_left;

	clock_gen u_clk (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n)
	);

	rms_top dut (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.src_empty     (src_empty),
		.src_readdata  (src_readdata),
		.snk_full      (snk_full),
		.src_read      (src_read),
		.snk_write     (snk_write),
		.snk_writedata (snk_writedata),
		.hex0          (hex0),
		.hex1          (hex1),
		.hex2          (hex2),
		.hex3          (hex3),
		.hex4          (hex4),
		.hex5          (hex5)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	// Galois LFSR with taps x^32 + x^30 + x^26 + x^25 + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hA300_0000;
		return n;
	endfunction

	// One step per bit taken
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < width; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	// Active-low digit table with bit 0 as segment a
	function automatic logic [6:0] segment_pattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'ha: return 7'h08;
			4'hb: return 7'h03;
			4'hc: return 7'h46;
			4'hd: return 7'h21;
			4'he: return 7'h06;
			default: return 7'h0e;
		endcase
	endfunction

	// Floor root of the floor mean of squares over the first k samples of the window
	function automatic logic [15:0] reference_rms(input int n);
		int k;
		int i;
		int b;
		logic [63:0] acc;
		logic [63:0] mean;
		logic [15:0] r;
		logic [15:0] trial;
		k = n % WINDOW_LEN + 1;
		acc = '0;
		for (i = n - k + 1; i <= n; i++)
			acc = acc + 64'(sent_samples[i]) * 64'(sent_samples[i]);
		mean = acc / 64'(k);
		r = '0;
		// Greedy search from the top bit down
		for (b = 15; b >= 0; b--)
		begin
			trial = r | (16'h1 << b);
			if (64'(trial) * 64'(trial) <= mean)
				r = trial;
		end
		return r;
	endfunction

	task automatic check_display(input string name, input logic [15:0] root,
		input logic [3:0] pos);
		check_value({name, " hex0"}, segment_pattern(root[3:0]), hex0);
		check_value({name, " hex1"}, segment_pattern(root[7:4]), hex1);
		check_value({name, " hex2"}, segment_pattern(root[11:8]), hex2);
		check_value({name, " hex3"}, segment_pattern(root[15:12]), hex3);
		check_value({name, " hex4"}, segment_pattern(pos), hex4);
		check_value({name, " hex5"}, segment_pattern(4'h0), hex5);
	endtask

	// Queue push on the falling edge keeps clear of the FIFO model
	task automatic send_sample(input logic [WORD_W-1:0] word);
		@(negedge CLOCK_50);
		src_queue.push_back(word);
		sent_samples[samples_sent] = word[SAMPLE_W-1:0];
		samples_sent++;
	endtask

	task automatic send_random_sample();
		logic [WORD_W-1:0] word;
		@(negedge CLOCK_50);
		// Upper half random too
		word = random_bits(WORD_W);
		src_queue.push_back(word);
		sent_samples[samples_sent] = word[SAMPLE_W-1:0];
		samples_sent++;
	endtask

	task automatic wait_for_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 100)
		begin
			@(posedge CLOCK_50);
			cycles++;
		end
		if (rst_n !== 1'b1)
			report_failure("reset was never released");
	endtask

	task automatic wait_for_results(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (results_seen < target && cycles < limit)
		begin
			@(posedge CLOCK_50);
			cycles++;
		end
		if (results_seen < target)
			report_failure("timed out waiting for results on the sink FIFO");
	endtask

	//////////////////////////////////////////////////
	// FIFO models
	//////////////////////////////////////////////////

	// Popped word appears the cycle after the read pulse
	always @(posedge CLOCK_50)
	begin
		if (src_read === 1'b1)
		begin
			if (src_queue.size() == 0)
				report_failure("read pulse while the source FIFO was empty");
			else
				src_readdata <= src_queue.pop_front();
		end
		src_empty <= (src_queue.size() == 0);
	end

	// Full flag in random stretches of 1 to 8 cycles
	always @(posedge CLOCK_50)
	begin
		if (backpressure_en)
		begin
			if (stretch_left == 0)
			begin
				full_level = 1'(random_bits(1));
				stretch_left = random_bits(3) + 1;
			end
			stretch_left--;
			snk_full <= full_level;
		end
		else
			snk_full <= 1'b0;
	end

	// Checker for every write
	always @(negedge CLOCK_50)
	begin
		if (rst_n && snk_write === 1'b1)
		begin
			if (results_seen >= samples_sent)
				report_failure("sink write with no sample outstanding");
			check_value("write while full", 1'b0, snk_full);
			check_value("upper result bits", 16'h0, snk_writedata[31:16]);
			check_value("result word", reference_rms(results_seen), snk_writedata);
			// Display already holds this result
			check_display("display after write", reference_rms(results_seen),
				4'(results_seen % WINDOW_LEN + 1));
			last_word = snk_writedata;
			results_seen++;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial
	begin
		src_empty = 1'b1;
		src_readdata = '0;
		snk_full = 1'b0;
		samples_sent = 0;
		results_seen = 0;
		last_word = '0;
		lfsr_state = 32'd66965;
		backpressure_en = 1'b0;
		full_level = 1'b0;
		stretch_left = 0;

		wait_for_reset_release();

		// Quiet after reset
		repeat (50)
		begin
			@(negedge CLOCK_50);
			check_value("idle src_read", 1'b0, src_read);
			check_value("idle snk_write", 1'b0, snk_write);
		end
		check_display("reset display", 16'h0, 4'h0);

		// Single known sample
		send_sample(32'd3);
		wait_for_results(1, 500);
		check_value("single sample", 32'd3, last_word);

		// Rest of the first window
		send_sample(32'd4);
		send_sample(32'd12);
		send_sample(32'd1000);
		send_sample(32'd65535);
		wait_for_results(5, 2000);

		// Random samples under back-pressure across window ends
		@(negedge CLOCK_50);
		backpressure_en = 1'b1;
		repeat (20)
			send_random_sample();
		wait_for_results(25, 20000);
		@(negedge CLOCK_50);
		backpressure_en = 1'b0;

		// Idle time with no further output expected
		repeat (200) @(posedge CLOCK_50);
		check_display("final display", reference_rms(samples_sent - 1),
			4'((samples_sent - 1) % WINDOW_LEN + 1));

		if (results_seen == samples_sent && src_queue.size() == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("sent %0d samples but saw %0d results", samples_sent, results_seen);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- list.f
logic/rms_pkg.sv
logic/fifo_sample_reader.sv
logic/rms_accumulator.sv
logic/int_divider.sv
logic/int_sqrt.sv
logic/fifo_result_writer.sv
logic/hex_display.sv
logic/rms_top.sv
dv/clock_gen.sv
dv/rms_tb.sv

//--- logic/fifo_result_writer.sv
`default_nettype none

module fifo_result_writer
	import rms_pkg::*;
(
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              result_strobe,
	input  logic [ROOT_W-1:0] result_root,
	input  logic              snk_full,
	output logic              writer_busy,
	output logic              snk_write,
	output logic [WORD_W-1:0] snk_writedata
);

	writer_state_t state_q;

	// Write goes out in the same cycle that full is seen low
	always_comb
	begin
		snk_write = (state_q == WR_WAIT_SPACE) && !snk_full;
		writer_busy = (state_q != WR_IDLE);
	end

	//////////////////////////////////////////////////
	// Hold result until the sink has room
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= WR_IDLE;
		else
		begin
			case (state_q)
				WR_IDLE:
				begin
					if (result_strobe)
						state_q <= WR_WAIT_SPACE;
				end
				WR_WAIT_SPACE:
				begin
					if (!snk_full)
						state_q <= WR_WRITE;
				end
				default:
				begin
					// One cycle after the pulse before taking the next result
					state_q <= WR_IDLE;
				end
			endcase
		end
	end

	// Zero-extended root
	always_ff @(posedge CLOCK_50)
	begin
		if (result_strobe && state_q == WR_IDLE)
			snk_writedata <= WORD_W'(result_root);
	end

endmodule

`default_nettype wire

//--- logic/fifo_sample_reader.sv
`default_nettype none

module fifo_sample_reader
	import rms_pkg::*;
(
	input  logic                CLOCK_50,
	input  logic                rst_n,
	input  logic                src_empty,
	input  logic [WORD_W-1:0]   src_readdata,
	input  logic                busy,
	output logic                src_read,
	output logic                sample_strobe,
	output logic [SAMPLE_W-1:0] sample
);

	reader_state_t state_q;

	//////////////////////////////////////////////////
	// Poll, pop, capture, hand over
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= RD_IDLE;
			src_read <= 1'b0;
			sample_strobe <= 1'b0;
		end
		else
		begin
			// Pulses last a single cycle
			src_read <= 1'b0;
			sample_strobe <= 1'b0;
			case (state_q)
				RD_IDLE:
				begin
					// Only one sample in flight
					if (!src_empty && !busy)
					begin
						src_read <= 1'b1;
						state_q <= RD_READ;
					end
				end
				RD_READ:
				begin
					// Popped word shows up next cycle
					state_q <= RD_CAPTURE;
				end
				RD_CAPTURE:
				begin
					sample_strobe <= 1'b1;
					state_q <= RD_WAIT_PROC;
				end
				default:
				begin
					// Busy rises a cycle after the strobe, so strobe must be gone too
					if (!sample_strobe && !busy)
						state_q <= RD_IDLE;
				end
			endcase
		end
	end

	// Low half of the word is the sample
	always_ff @(posedge CLOCK_50)
	begin
		if (state_q == RD_CAPTURE)
			sample <= src_readdata[SAMPLE_W-1:0];
	end

endmodule

`default_nettype wire

//--- logic/hex_display.sv
`default_nettype none

module hex_display
	import rms_pkg::*;
(
	input  logic               CLOCK_50,
	input  logic               rst_n,
	input  logic               result_strobe,
	input  logic [ROOT_W-1:0]  result_root,
	input  logic [COUNT_W-1:0] window_pos,
	output logic [6:0]         hex0,
	output logic [6:0]         hex1,
	output logic [6:0]         hex2,
	output logic [6:0]         hex3,
	output logic [6:0]         hex4,
	output logic [6:0]         hex5
);

	logic [ROOT_W-1:0] root_q;
	logic [COUNT_W-1:0] pos_q;

	//////////////////////////////////////////////////
	// Last result shown on the board
	//////////////////////////////////////////////////

	// Cleared so the digits read zero out of reset
	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			root_q <= '0;
			pos_q <= '0;
		end
		else if (result_strobe)
		begin
			root_q <= result_root;
			pos_q <= window_pos;
		end
	end

	always_comb
	begin
		// Root, lowest nibble on digit 0
		hex0 = seg_of_nibble(root_q[3:0]);
		hex1 = seg_of_nibble(root_q[7:4]);
		hex2 = seg_of_nibble(root_q[11:8]);
		hex3 = seg_of_nibble(root_q[15:12]);
		// Position within the window
		hex4 = seg_of_nibble(pos_q);
		// Unused digit
		hex5 = seg_of_nibble(4'h0);
	end

endmodule

`default_nettype wire

//--- logic/int_divider.sv
`default_nettype none

module int_divider
	import rms_pkg::*;
(
	input  logic               CLOCK_50,
	input  logic               rst_n,
	input  logic               div_start,
	input  logic [SUM_W-1:0]   dividend,
	input  logic [COUNT_W-1:0] divisor,
	output logic               div_done,
	output logic [MEAN_W-1:0]  quotient
);

	logic active_q;
	logic [DIV_ITER_W-1:0] iter_q;
	// Dividend shifts out the top while quotient bits shift in below
	logic [SUM_W-1:0] dvd_q;
	logic [COUNT_W-1:0] rem_q;
	logic [COUNT_W-1:0] dsr_q;
	logic [COUNT_W:0] rem_shift;
	logic [COUNT_W:0] rem_diff;
	logic q_bit;
	logic [COUNT_W-1:0] rem_next;
	logic [SUM_W-1:0] dvd_next;
	logic last_iter;

	//////////////////////////////////////////////////
	// One restoring step
	//////////////////////////////////////////////////

	always_comb
	begin
		rem_shift = {rem_q, dvd_q[SUM_W-1]};
		rem_diff = rem_shift - {1'b0, dsr_q};
		// No borrow means the divisor fits
		q_bit = ~rem_diff[COUNT_W];
		rem_next = q_bit ? rem_diff[COUNT_W-1:0] : rem_shift[COUNT_W-1:0];
		dvd_next = {dvd_q[SUM_W-2:0], q_bit};
		last_iter = active_q && (iter_q == DIV_ITER_W'(1));
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_q <= 1'b0;
			iter_q <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= last_iter;
			if (div_start)
			begin
				active_q <= 1'b1;
				iter_q <= DIV_ITER_W'(SUM_W);
			end
			else if (active_q)
			begin
				iter_q <= iter_q - 1'b1;
				if (last_iter)
					active_q <= 1'b0;
			end
		end
	end

	// Datapath
	always_ff @(posedge CLOCK_50)
	begin
		if (div_start)
		begin
			dvd_q <= dividend;
			rem_q <= '0;
			dsr_q <= divisor;
		end
		else if (active_q)
		begin
			dvd_q <= dvd_next;
			rem_q <= rem_next;
		end
		// Mean of a window always fits in MEAN_W
		if (last_iter)
			quotient <= dvd_next[MEAN_W-1:0];
	end

endmodule

`default_nettype wire

//--- logic/int_sqrt.sv
`default_nettype none

module int_sqrt
	import rms_pkg::*;
(
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              sqrt_start,
	input  logic [MEAN_W-1:0] radicand,
	output logic              sqrt_done,
	output logic [ROOT_W-1:0] root
);

	logic active_q;
	logic [SQRT_ITER_W-1:0] iter_q;
	logic [MEAN_W-1:0] rad_q;
	// Two's complement remainder, MSB is the sign
	logic [SQRT_REM_W-1:0] rem_q;
	logic [ROOT_W-1:0] root_q;
	logic [SQRT_REM_W-1:0] rem_shift;
	logic [SQRT_REM_W-1:0] rem_next;
	logic [ROOT_W-1:0] root_next;
	logic last_iter;

	//////////////////////////////////////////////////
	// Non-restoring step, one root bit
	//////////////////////////////////////////////////

	always_comb
	begin
		// Bring down the next bit pair
		rem_shift = {rem_q[SQRT_REM_W-3:0], rad_q[MEAN_W-1:MEAN_W-2]};
		if (rem_q[SQRT_REM_W-1])
			rem_next = rem_shift + {1'b0, root_q, 2'b11};
		else
			rem_next = rem_shift - {1'b0, root_q, 2'b01};
		// Non-negative remainder gives a one
		root_next = {root_q[ROOT_W-2:0], ~rem_next[SQRT_REM_W-1]};
		last_iter = active_q && (iter_q == SQRT_ITER_W'(1));
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_q <= 1'b0;
			iter_q <= '0;
			sqrt_done <= 1'b0;
		end
		else
		begin
			sqrt_done <= last_iter;
			if (sqrt_start)
			begin
				active_q <= 1'b1;
				iter_q <= SQRT_ITER_W'(ROOT_W);
			end
			else if (active_q)
			begin
				iter_q <= iter_q - 1'b1;
				if (last_iter)
					active_q <= 1'b0;
			end
		end
	end

	// Datapath
	always_ff @(posedge CLOCK_50)
	begin
		if (sqrt_start)
		begin
			rad_q <= radicand;
			rem_q <= '0;
			root_q <= '0;
		end
		else if (active_q)
		begin
			rad_q <= {rad_q[MEAN_W-3:0], 2'b00};
			rem_q <= rem_next;
			root_q <= root_next;
		end
		// Floor root, remainder is not needed
		if (last_iter)
			root <= root_next;
	end

endmodule

`default_nettype wire

//--- logic/rms_accumulator.sv
`default_nettype none

module rms_accumulator
	import rms_pkg::*;
(
	input  logic                CLOCK_50,
	input  logic                rst_n,
	input  logic                sample_strobe,
	input  logic [SAMPLE_W-1:0] sample,
	input  logic                div_done,
	input  logic [MEAN_W-1:0]   quotient,
	input  logic                sqrt_done,
	input  logic [ROOT_W-1:0]   root,
	input  logic                writer_busy,
	output logic                busy,
	output logic                div_start,
	output logic [SUM_W-1:0]    sum,
	output logic [COUNT_W-1:0]  count,
	output logic                sqrt_start,
	output logic [MEAN_W-1:0]   mean_out,
	output logic                result_strobe,
	output logic [ROOT_W-1:0]   result_root,
	output logic [COUNT_W-1:0]  window_pos
);

	proc_state_t state_q;
	logic [2*SAMPLE_W-1:0] square;
	logic emit_now;

	// Sample stays put in the reader until busy drops
	always_comb
	begin
		square = sample * sample;
		emit_now = (state_q == PROC_EMIT) && !writer_busy;
	end

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= PROC_IDLE;
			busy <= 1'b0;
			div_start <= 1'b0;
			sqrt_start <= 1'b0;
			result_strobe <= 1'b0;
			sum <= '0;
			count <= '0;
		end
		else
		begin
			div_start <= 1'b0;
			sqrt_start <= 1'b0;
			result_strobe <= 1'b0;
			case (state_q)
				PROC_IDLE:
				begin
					if (sample_strobe)
					begin
						busy <= 1'b1;
						state_q <= PROC_ACCUM;
					end
				end
				PROC_ACCUM:
				begin
					// Divider picks up the new sum and count with the start pulse
					sum <= sum + SUM_W'(square);
					count <= count + 1'b1;
					div_start <= 1'b1;
					state_q <= PROC_DIVIDE;
				end
				PROC_DIVIDE:
				begin
					if (div_done)
					begin
						sqrt_start <= 1'b1;
						state_q <= PROC_ROOT;
					end
				end
				PROC_ROOT:
				begin
					if (sqrt_done)
						state_q <= PROC_EMIT;
				end
				default:
				begin
					// Hold the result until the writer is free
					if (emit_now)
					begin
						result_strobe <= 1'b1;
						busy <= 1'b0;
						state_q <= PROC_IDLE;
						// End of window
						if (count == COUNT_W'(WINDOW_LEN))
						begin
							sum <= '0;
							count <= '0;
						end
					end
				end
			endcase
		end
	end

	// Results of each step
	always_ff @(posedge CLOCK_50)
	begin
		if (div_done && state_q == PROC_DIVIDE)
			mean_out <= quotient;
		if (sqrt_done && state_q == PROC_ROOT)
			result_root <= root;
		if (emit_now)
			window_pos <= count;
	end

endmodule

`default_nettype wire

//--- logic/rms_pkg.sv
`default_nettype none

package rms_pkg;

	//////////////////////////////////////////////////
	// Data widths
	//////////////////////////////////////////////////

	// Host FIFO word
	localparam int WORD_W = 32;
	// Sample sits in the low bits of a word
	localparam int SAMPLE_W = 16;
	// Room for WINDOW_LEN full-scale squares
	localparam int SUM_W = 40;
	localparam int MEAN_W = 32;
	localparam int ROOT_W = 16;

	// Samples per window
	localparam int WINDOW_LEN = 8;
	localparam int COUNT_W = 4;

	// Iteration counters for the divider and the root unit
	localparam int DIV_ITER_W = $clog2(SUM_W + 1);
	localparam int SQRT_ITER_W = $clog2(ROOT_W + 1);
	// Signed partial remainder of the root, two guard bits plus sign
	localparam int SQRT_REM_W = ROOT_W + 3;

	//////////////////////////////////////////////////
	// FSM encodings
	//////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		RD_IDLE,
		RD_READ,
		RD_CAPTURE,
		RD_WAIT_PROC
	} reader_state_t;

	typedef enum logic [2:0]
	{
		PROC_IDLE,
		PROC_ACCUM,
		PROC_DIVIDE,
		PROC_ROOT,
		PROC_EMIT
	} proc_state_t;

	typedef enum logic [1:0]
	{
		WR_IDLE,
		WR_WAIT_SPACE,
		WR_WRITE
	} writer_state_t;

	// Active-low segments, bit 0 is segment a
	function automatic logic [6:0] seg_of_nibble(input logic [3:0] nibble);
		logic [6:0] seg;
		case (nibble)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire

//--- logic/rms_top.sv
`default_nettype none

module rms_top
	import rms_pkg::*;
(
	input  logic              CLOCK_50,
	input  logic              rst_n,
	input  logic              src_empty,
	input  logic [WORD_W-1:0] src_readdata,
	input  logic              snk_full,
	output logic              src_read,
	output logic              snk_write,
	output logic [WORD_W-1:0] snk_writedata,
	output logic [6:0]        hex0,
	output logic [6:0]        hex1,
	output logic [6:0]        hex2,
	output logic [6:0]        hex3,
	output logic [6:0]        hex4,
	output logic [6:0]        hex5
);

	// Reader to accumulator
	logic sample_strobe;
	logic [SAMPLE_W-1:0] sample;
	logic busy;
	// Divider
	logic div_start;
	logic div_done;
	logic [SUM_W-1:0] sum;
	logic [COUNT_W-1:0] count;
	logic [MEAN_W-1:0] quotient;
	// Root unit
	logic sqrt_start;
	logic sqrt_done;
	logic [MEAN_W-1:0] mean_out;
	logic [ROOT_W-1:0] root;
	// Result toward writer and display
	logic result_strobe;
	logic [ROOT_W-1:0] result_root;
	logic [COUNT_W-1:0] window_pos;
	logic writer_busy;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	fifo_sample_reader u_reader (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.src_empty     (src_empty),
		.src_readdata  (src_readdata),
		.busy          (busy),
		.src_read      (src_read),
		.sample_strobe (sample_strobe),
		.sample        (sample)
	);

	//////////////////////////////////////////////////
	// Processing
	//////////////////////////////////////////////////

	rms_accumulator u_accum (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.div_done      (div_done),
		.quotient      (quotient),
		.sqrt_done     (sqrt_done),
		.root          (root),
		.writer_busy   (writer_busy),
		.busy          (busy),
		.div_start     (div_start),
		.sum           (sum),
		.count         (count),
		.sqrt_start    (sqrt_start),
		.mean_out      (mean_out),
		.result_strobe (result_strobe),
		.result_root   (result_root),
		.window_pos    (window_pos)
	);

	// Sum over samples so far
	int_divider u_div (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.div_start (div_start),
		.dividend  (sum),
		.divisor   (count),
		.div_done  (div_done),
		.quotient  (quotient)
	);

	int_sqrt u_sqrt (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.sqrt_start (sqrt_start),
		.radicand   (mean_out),
		.sqrt_done  (sqrt_done),
		.root       (root)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	fifo_result_writer u_writer (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.result_strobe (result_strobe),
		.result_root   (result_root),
		.snk_full      (snk_full),
		.writer_busy   (writer_busy),
		.snk_write     (snk_write),
		.snk_writedata (snk_writedata)
	);

	hex_display u_hex (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.result_strobe (result_strobe),
		.result_root   (result_root),
		.window_pos    (window_pos),
		.hex0          (hex0),
		.hex1          (hex1),
		.hex2          (hex2),
		.hex3          (hex3),
		.hex4          (hex4),
		.hex5          (hex5)
	);

endmodule

`default_nettype wire
